// ==== list.f ====
+incdir+hw
hw/dcache_pkg.sv
hw/ls_req_if.sv
hw/mem_bus_if.sv
hw/pipe_queue.sv
hw/dcache_ctrl.sv
hw/backing_mem.sv
hw/dcache_top.sv
sim/clk_gen.sv
sim/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the data-cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_dcache -f list.f \
  -Mdir obj_dir -o tb_dcache_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_dcache_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
  echo "Test passed"
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// ==== sim/tb_dcache.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module tb_dcache import dcache_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [`DC_ADDR_BITS-1:0] addr_t;

  // Upper bound on requests over the whole run
  localparam int NUM_REQS    = 260;
  localparam int WATCHDOG_NS = (NUM_REQS * 10 + 2000) * 100;
  localparam int WAIT_LIMIT  = 200;

  logic        CLK;
  logic        nRST;
  logic        req_valid;
  logic        req_ready;
  logic        req_write;
  addr_t       req_addr;
  word_t       req_wdata;
  logic        rsp_ready;
  logic        rsp_valid;
  word_t       rsp_rdata;
  logic        flush;
  logic        flushed;

  // Reference memory by word index and the loads still owed a response
  word_t       ref_mem [int];
  word_t       expected [$];
  logic [31:0] lfsr_state = 32'had4c;

  clk_gen #(.PERIOD_NS(100)) i_clk_gen (.CLK(CLK));

  dcache_top i_dcache_top (
    .CLK       (CLK),
    .nRST      (nRST),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .rsp_ready (rsp_ready),
    .flush     (flush),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .flushed   (flushed)
  );

  // Galois LFSR stepped once per bit handed out
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] bits;
    int          i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return bits;
  endfunction

  // Backing memory wraps at its depth
  function automatic int mem_index(addr_t addr);
    return int'((addr >> 2) % `DC_MEM_WORDS);
  endfunction

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic compare_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] %t %s: expected %h, got %h", $time, name, exp, got));
    end
  endtask

  task automatic compare_logic(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] %t %s: expected %b, got %b", $time, name, exp, got));
    end
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #10;
  endtask

  // Holds the request until the queue takes it, then updates the model
  task automatic issue_req(logic wr, addr_t addr, word_t data);
    int n;
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_wdata = data;
    n = 0;
    while (!req_ready) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) begin
        stop_with_failure("Request queue did not accept a request in time");
      end
    end
    next_cycle();
    req_valid = 1'b0;
    if (wr) begin
      ref_mem[mem_index(addr)] = data;
    end else if (ref_mem.exists(mem_index(addr))) begin
      expected.push_back(ref_mem[mem_index(addr)]);
    end else begin
      expected.push_back('0);
    end
  endtask

  task automatic collect_rsp();
    int    n;
    word_t got;
    n = 0;
    while (!rsp_valid) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) begin
        stop_with_failure("No load response arrived in time");
      end
    end
    got = rsp_rdata;
    rsp_ready = 1'b1;
    next_cycle();
    rsp_ready = 1'b0;
    if (expected.size() == 0) begin
      stop_with_failure("A load response arrived with no load outstanding");
    end
    compare_word("rsp_rdata", got, expected.pop_front());
  endtask

  task automatic load_and_check(addr_t addr);
    issue_req(1'b0, addr, '0);
    collect_rsp();
  endtask

  task automatic read_cold_memory();
    int i;
    compare_logic("rsp_valid", rsp_valid, 1'b0);
    compare_logic("flushed", flushed, 1'b0);
    for (i = 0; i < 4; i++) begin
      load_and_check(take_bits(30) << 2);
    end
  endtask

  task automatic store_then_load();
    addr_t a;
    a = take_bits(6) << 2;
    issue_req(1'b1, a, take_bits(32));
    load_and_check(a);
    // Other word of the same block
    load_and_check(a ^ 32'h4);
  endtask

  // Three tags in one set, so one dirty way must be evicted
  task automatic evict_dirty_way();
    addr_t a [3];
    addr_t set;
    int    t;
    set = take_bits(3);
    for (t = 0; t < 3; t++) begin
      a[t] = ((32'(t) + 32'd5) << 6) | (set << 3) | (take_bits(1) << 2);
      issue_req(1'b1, a[t], take_bits(32));
    end
    for (t = 0; t < 3; t++) begin
      load_and_check(a[t]);
    end
  endtask

  task automatic hold_back_responses();
    addr_t base;
    word_t d;
    int    n;
    int    i;
    base = take_bits(6) << 2;
    d = take_bits(32);
    // Different data in the two words of the block makes the order visible
    issue_req(1'b1, base, d);
    issue_req(1'b1, base ^ 32'h4, ~d);
    load_and_check(base);
    // Hits only, so the response queue fills first
    n = 0;
    while (req_ready && n < 16) begin
      issue_req(1'b0, (n % 2 != 0) ? (base ^ 32'h4) : base, '0);
      n++;
    end
    if (req_ready) begin
      stop_with_failure("req_ready stayed high while rsp_ready was held low");
    end
    for (i = 0; i < n; i++) begin
      collect_rsp();
    end
    for (i = 0; i < 10; i++) begin
      next_cycle();
      compare_logic("rsp_valid", rsp_valid, 1'b0);
    end
  endtask

  task automatic flush_and_reload();
    addr_t a [8];
    int    n;
    int    i;
    for (i = 0; i < 8; i++) begin
      a[i] = take_bits(6) << 2;
      issue_req(1'b1, a[i], take_bits(32));
    end
    flush = 1'b1;
    n = 0;
    while (!flushed) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT * 2) begin
        stop_with_failure("flushed did not rise after flush was raised");
      end
    end
    for (i = 0; i < 5; i++) begin
      next_cycle();
      compare_logic("flushed", flushed, 1'b1);
    end
    flush = 1'b0;
    next_cycle();
    compare_logic("flushed", flushed, 1'b0);
    // Every way is invalid now, so the first load needs two memory transfers
    issue_req(1'b0, a[0], '0);
    n = 0;
    while (!rsp_valid) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) begin
        stop_with_failure("No load response arrived in time");
      end
    end
    if (n <= 2 * (`DC_MEM_WAIT + 1)) begin
      stop_with_failure("First load after the flush was served without a memory fill");
    end
    collect_rsp();
    // The rest come back from memory or from blocks refilled since
    for (i = 1; i < 8; i++) begin
      load_and_check(a[i]);
    end
  endtask

  task automatic run_random_mix();
    addr_t a;
    int    i;
    for (i = 0; i < 200; i++) begin
      a = take_bits(6) << 2;
      if (take_bits(1) != 0) begin
        issue_req(1'b1, a, take_bits(32));
      end else begin
        load_and_check(a);
      end
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("Watchdog expired before all tests finished");
  end

  initial begin
    $timeformat(-9, 0, " ns", 0);
    nRST      = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    rsp_ready = 1'b0;
    flush     = 1'b0;
    repeat (5) @(posedge CLK);
    #10;
    compare_logic("req_ready", req_ready, 1'b0);
    nRST = 1'b1;
    next_cycle();
    read_cold_memory();
    store_then_load();
    evict_dirty_way();
    hold_back_responses();
    flush_and_reload();
    run_random_mix();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/clk_gen.sv ====
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic CLK
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module dcache_top import dcache_pkg::*; (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     req_valid,
  input  logic                     req_write,
  input  logic [`DC_ADDR_BITS-1:0] req_addr,
  input  word_t                    req_wdata,
  input  logic                     rsp_ready,
  input  logic                     flush,
  output logic                     req_ready,
  output logic                     rsp_valid,
  output word_t                    rsp_rdata,
  output logic                     flushed
);

  ls_req_if #(.T(ls_req_t)) core_req_if ();
  ls_req_if #(.T(ls_req_t)) req_if ();
  ls_req_if #(.T(word_t))   rsp_if ();
  ls_req_if #(.T(word_t))   core_rsp_if ();
  mem_bus_if                mem_if ();

  // Core side of the request queue
  assign core_req_if.valid   = req_valid;
  assign core_req_if.payload = '{write: req_write, addr: req_addr, wdata: req_wdata};
  assign req_ready           = core_req_if.ready;

  // Core side of the response queue
  assign core_rsp_if.ready = rsp_ready;
  assign rsp_valid         = core_rsp_if.valid;
  assign rsp_rdata         = core_rsp_if.payload;

  pipe_queue #(.T(ls_req_t), .DEPTH(`DC_QUEUE_DEPTH)) i_req_queue (
    .CLK  (CLK),
    .nRST (nRST),
    .in   (core_req_if),
    .out  (req_if)
  );

  dcache_ctrl i_dcache_ctrl (
    .CLK     (CLK),
    .nRST    (nRST),
    .req     (req_if),
    .rsp     (rsp_if),
    .mem     (mem_if),
    .flush   (flush),
    .flushed (flushed)
  );

  pipe_queue #(.T(word_t), .DEPTH(`DC_QUEUE_DEPTH)) i_rsp_queue (
    .CLK  (CLK),
    .nRST (nRST),
    .in   (rsp_if),
    .out  (core_rsp_if)
  );

  backing_mem i_backing_mem (
    .CLK  (CLK),
    .nRST (nRST),
    .bus  (mem_if)
  );

endmodule

`default_nettype wire

// ==== hw/backing_mem.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module backing_mem import dcache_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  mem_bus_if.mem  bus
);

  localparam int IW = $clog2(`DC_MEM_WORDS);
  localparam int CW = $clog2(`DC_MEM_WAIT + 2);

  word_t [`DC_MEM_WORDS-1:0] mem_array;

  logic [CW-1:0]           wait_cnt;
  logic                    active;
  logic                    done;
  logic [IW-1:0]           word_idx;
  logic [`DC_ADDR_BITS-1:0] byte_addr;

  assign byte_addr = bus.addr;
  // Word address, wrapped to the array depth
  assign word_idx  = byte_addr[DC_BYTE_BITS +: IW];

  assign active = bus.ren || bus.wen;
  assign done   = active && (wait_cnt == CW'(`DC_MEM_WAIT));

  assign bus.mem_wait = !done;
  assign bus.rdata    = mem_array[word_idx];

  // Counter restarts after each completed transfer
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (!active || done) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mem_array <= '0;
    end else if (done && bus.wen) begin
      mem_array[word_idx] <= bus.wdata;
    end
  end

endmodule

`default_nettype wire

// ==== hw/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  ls_req_if.sink    req,
  ls_req_if.source  rsp,
  mem_bus_if.cache  mem,
  input  logic      flush,
  output logic      flushed
);

  localparam int FCW = DC_IDX_BITS + 2;

  dc_state_t state;
  dc_state_t next_state;

  dc_frame_t [DC_SETS-1:0][1:0] frames;
  logic      [DC_SETS-1:0]      lru;

  ls_req_t                rq;
  logic [DC_IDX_BITS-1:0] idx;
  dc_frame_t              f0;
  dc_frame_t              f1;
  logic                   hit0;
  logic                   hit1;
  logic                   hit_way;
  logic                   hit_go;
  logic                   victim_way;
  logic                   victim_q;
  dc_frame_t              wb_frame;
  logic                   mem_done;
  logic                   blk;

  // Flush walk: way 0 of every set, then way 1, then done bit
  logic [FCW-1:0]         flush_cnt;
  logic [DC_IDX_BITS-1:0] flush_set;
  logic                   flush_way;
  logic                   flush_end;
  dc_frame_t              fl_frame;

  assign rq  = req.payload;
  assign idx = rq.addr.idx;
  assign f0  = frames[idx][0];
  assign f1  = frames[idx][1];

  assign hit0    = f0.valid && (f0.tag == rq.addr.tag);
  assign hit1    = f1.valid && (f1.tag == rq.addr.tag);
  assign hit_way = hit1;

  // Fill an empty way first, else evict the LRU one
  assign victim_way = !f0.valid ? 1'b0 : (!f1.valid ? 1'b1 : lru[idx]);
  assign wb_frame   = frames[idx][victim_q];

  assign flush_set = flush_cnt[DC_IDX_BITS-1:0];
  assign flush_way = flush_cnt[DC_IDX_BITS];
  assign flush_end = flush_cnt[DC_IDX_BITS+1];
  assign fl_frame  = frames[flush_set][flush_way];

  assign mem_done = !mem.mem_wait;
  assign blk = (state == ST_WB1) || (state == ST_LOAD1) || (state == ST_FWR1);

  always_comb begin
    next_state  = state;
    hit_go      = 1'b0;
    req.ready   = 1'b0;
    rsp.valid   = 1'b0;
    rsp.payload = hit1 ? f1.data[rq.addr.blkoff] : f0.data[rq.addr.blkoff];
    mem.ren     = 1'b0;
    mem.wen     = 1'b0;
    mem.addr    = '0;
    mem.wdata   = '0;
    flushed     = 1'b0;

    case (state)
      ST_IDLE: begin
        if (flush && !req.valid) begin
          next_state = ST_SCAN;
        end else if (req.valid) begin
          if (hit0 || hit1) begin
            // Loads wait for room in the response queue
            if (rq.write || rsp.ready) begin
              hit_go    = 1'b1;
              req.ready = 1'b1;
              rsp.valid = !rq.write;
            end
          end else if (frames[idx][victim_way].dirty) begin
            next_state = ST_WB0;
          end else begin
            next_state = ST_LOAD0;
          end
        end
      end

      ST_WB0, ST_WB1: begin
        mem.wen   = 1'b1;
        mem.addr  = '{tag: wb_frame.tag, idx: idx, blkoff: blk, bytoff: '0};
        mem.wdata = wb_frame.data[blk];
        if (mem_done) begin
          next_state = (state == ST_WB0) ? ST_WB1 : ST_LOAD0;
        end
      end

      ST_LOAD0, ST_LOAD1: begin
        mem.ren  = 1'b1;
        mem.addr = '{tag: rq.addr.tag, idx: idx, blkoff: blk, bytoff: '0};
        if (mem_done) begin
          // Back to idle, where the request now hits
          next_state = (state == ST_LOAD0) ? ST_LOAD1 : ST_IDLE;
        end
      end

      ST_SCAN: begin
        if (flush_end) begin
          next_state = ST_FDONE;
        end else if (fl_frame.dirty) begin
          next_state = ST_FWR0;
        end
      end

      ST_FWR0, ST_FWR1: begin
        mem.wen   = 1'b1;
        mem.addr  = '{tag: fl_frame.tag, idx: flush_set, blkoff: blk, bytoff: '0};
        mem.wdata = fl_frame.data[blk];
        if (mem_done) begin
          next_state = (state == ST_FWR0) ? ST_FWR1 : ST_SCAN;
        end
      end

      ST_FDONE: begin
        flushed = 1'b1;
        if (!flush) begin
          next_state = ST_IDLE;
        end
      end

      default: next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= ST_IDLE;
      frames    <= '0;
      lru       <= '0;
      victim_q  <= 1'b0;
      flush_cnt <= '0;
    end else begin
      state <= next_state;
      case (state)
        ST_IDLE: begin
          if (hit_go) begin
            lru[idx] <= ~hit_way;
            if (rq.write) begin
              frames[idx][hit_way].data[rq.addr.blkoff] <= rq.wdata;
              frames[idx][hit_way].dirty <= 1'b1;
            end
          end
          if (req.valid && !(hit0 || hit1)) begin
            victim_q <= victim_way;
          end
          if (next_state == ST_SCAN) begin
            flush_cnt <= '0;
          end
        end

        ST_WB1: begin
          if (mem_done) begin
            frames[idx][victim_q].valid <= 1'b0;
            frames[idx][victim_q].dirty <= 1'b0;
          end
        end

        ST_LOAD0, ST_LOAD1: begin
          if (mem_done) begin
            frames[idx][victim_q].data[blk] <= mem.rdata;
            if (state == ST_LOAD1) begin
              frames[idx][victim_q].tag   <= rq.addr.tag;
              frames[idx][victim_q].valid <= 1'b1;
              frames[idx][victim_q].dirty <= 1'b0;
            end
          end
        end

        ST_SCAN: begin
          if (flush_end) begin
            lru <= '0;
          end else if (!fl_frame.dirty) begin
            // Clean way, drop it and move on
            frames[flush_set][flush_way].valid <= 1'b0;
            flush_cnt <= flush_cnt + 1'b1;
          end
        end

        ST_FWR1: begin
          if (mem_done) begin
            frames[flush_set][flush_way].valid <= 1'b0;
            frames[flush_set][flush_way].dirty <= 1'b0;
            flush_cnt <= flush_cnt + 1'b1;
          end
        end

        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/pipe_queue.sv ====
`default_nettype none

module pipe_queue #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic      CLK,
  input  logic      nRST,
  ls_req_if.sink    in,
  ls_req_if.source  out
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T               slots [DEPTH];
  logic [PW-1:0]  wr_ptr;
  logic [PW-1:0]  rd_ptr;
  logic [CW-1:0]  count;
  logic [CW-1:0]  count_next;
  logic           in_rdy;
  logic           push;
  logic           pop;

  assign push = in.valid && in_rdy;
  assign pop  = out.valid && out.ready;
  assign count_next = count + CW'(push) - CW'(pop);

  // Ready comes up one edge after reset
  assign in.ready    = in_rdy;
  assign out.valid   = (count != '0);
  assign out.payload = slots[rd_ptr];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      in_rdy <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count  <= count_next;
      in_rdy <= (count_next != CW'(DEPTH));
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      slots[wr_ptr] <= in.payload;
    end
  end

endmodule

`default_nettype wire

// ==== hw/mem_bus_if.sv ====
`default_nettype none

interface mem_bus_if import dcache_pkg::*; ();

  logic     ren;
  logic     wen;
  dc_addr_t addr;
  word_t    wdata;
  word_t    rdata;
  // Low only in the cycle a transfer completes
  logic     mem_wait;

  modport cache (output ren, wen, addr, wdata, input rdata, mem_wait);
  modport mem (input ren, wen, addr, wdata, output rdata, mem_wait);

endinterface

`default_nettype wire

// ==== hw/ls_req_if.sv ====
`default_nettype none

// Valid/ready channel carrying one payload of type T per transfer
interface ls_req_if #(
  parameter type T = logic
) ();

  logic valid;
  logic ready;
  T     payload;

  modport source (
    output valid,
    output payload,
    input  ready
  );

  modport sink (
    input  valid,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

// ==== hw/dcache_pkg.sv ====
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

  // Cache geometry, fixed at two ways and two-word blocks
  localparam int DC_SETS      = `DC_CACHE_BITS / (2 * 2 * `DC_WORD_BITS);
  localparam int DC_IDX_BITS  = $clog2(DC_SETS);
  localparam int DC_BYTE_BITS = $clog2(`DC_WORD_BITS / 8);
  localparam int DC_TAG_BITS  = `DC_ADDR_BITS - DC_IDX_BITS - 1 - DC_BYTE_BITS;

  typedef logic [`DC_WORD_BITS-1:0] word_t;

  typedef struct packed {
    logic [DC_TAG_BITS-1:0]  tag;
    logic [DC_IDX_BITS-1:0]  idx;
    logic                    blkoff;
    logic [DC_BYTE_BITS-1:0] bytoff;
  } dc_addr_t;

  typedef struct packed {
    logic                   valid;
    logic                   dirty;
    logic [DC_TAG_BITS-1:0] tag;
    word_t [1:0]            data;
  } dc_frame_t;

  typedef struct packed {
    logic     write;
    dc_addr_t addr;
    word_t    wdata;
  } ls_req_t;

  typedef enum logic [3:0] {
    // Request service
    ST_IDLE, ST_WB0, ST_WB1, ST_LOAD0, ST_LOAD1,
    // Flush sequence
    ST_SCAN, ST_FWR0, ST_FWR1, ST_FDONE
  } dc_state_t;

endpackage

`default_nettype wire

// ==== hw/dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Core-side address and data widths
`define DC_ADDR_BITS 32
`define DC_WORD_BITS 32

// 8 sets of 2 ways, 2 words per block
`define DC_CACHE_BITS 1024

// Backing memory depth in words
`define DC_MEM_WORDS 256

// Extra cycles a memory transfer is held off
`define DC_MEM_WAIT 2

// Entries in each request/response queue
`define DC_QUEUE_DEPTH 4

`endif
